/* common/link_pkg.sv */
/*
  Shared link receiver definitions: the lane byte type, the comma
  constant, the alignment comma count and the alignment state enum.
*/
`default_nettype none

package link_pkg;

  // One byte of lane data.
  typedef logic [7:0] byte_t;

  // Alignment and idle byte.
  localparam byte_t COMMA = 8'hBC;

  // Consecutive aligned commas before a lane is declared active.
  localparam int ALIGN_COMMAS = 4;

  // Alignment FSM of the deserializer.
  typedef enum logic [1:0] {
    hunt   = 2'd0,  // Searching for a comma at any bit offset.
    count  = 2'd1,  // Boundary fixed, counting aligned commas.
    locked = 2'd2   // Lane active, data bytes are emitted.
  } align_state_t;

endpackage

`default_nettype wire

/* rtl/credit_out.sv */
/*
  Per-lane credit-based output stage: pops the lane FIFO while credits
  remain and presents each byte registered with a one-cycle valid.
*/
`timescale 1ns/1ps
`default_nettype none

module credit_out #(
  parameter int CREDITS = 2
) (
  input  wire                  clk8f,
  input  wire                  rst,
  input  wire link_pkg::byte_t head_data,
  input  wire                  empty,
  output logic                 pop,
  input  wire                  credit_return,
  output link_pkg::byte_t      out_data,
  output logic                 out_valid
);

  localparam int CRD_W = $clog2(CREDITS + 1);

  logic [CRD_W-1:0] credits;

  assign pop = !empty && (credits != '0);

  always_ff @(posedge clk8f) begin
    if (rst) begin
      credits   <= CRD_W'(CREDITS);
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;
      case ({pop, credit_return})
        2'b10: credits <= credits - CRD_W'(1);
        2'b01: begin
          // Saturate so a surplus return is ignored.
          if (credits != CRD_W'(CREDITS)) begin
            credits <= credits + CRD_W'(1);
          end
        end
        default: credits <= credits;  // Send and return cancel out.
      endcase
    end
  end

  always_ff @(posedge clk8f) begin
    if (pop) begin
      out_data <= head_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/deser/serial_to_parallel.sv */
/*
  Per-lane deserializer: MSB-first bit shifter, comma hunt,
  alignment lock and emission of non-comma bytes.
*/
`timescale 1ns/1ps
`default_nettype none

module serial_to_parallel (
  input  wire                  clk8f,
  input  wire                  rst,
  input  wire                  ser_in,
  output link_pkg::byte_t      rx_byte,
  output logic                 rx_valid,
  output logic                 active
);

  localparam int CNT_W = $clog2(link_pkg::ALIGN_COMMAS + 1);

  link_pkg::align_state_t state;
  link_pkg::byte_t        shift;
  link_pkg::byte_t        next_shift;
  logic [2:0]             bit_cnt;
  logic [CNT_W-1:0]       comma_cnt;
  logic                   boundary;

  // The incoming bit is always the newest LSB of the shifted byte.
  assign next_shift = {shift[6:0], ser_in};
  assign boundary   = (bit_cnt == 3'd7);  // This bit completes a byte.
  assign active     = (state == link_pkg::locked);

  always_ff @(posedge clk8f) begin
    if (rst) begin
      state     <= link_pkg::hunt;
      shift     <= '0;
      bit_cnt   <= '0;
      comma_cnt <= '0;
      rx_valid  <= 1'b0;
    end else begin
      shift    <= next_shift;
      bit_cnt  <= bit_cnt + 3'd1;
      rx_valid <= 1'b0;
      case (state)
        link_pkg::hunt: begin
          // A comma at any offset fixes the byte boundary.
          if (next_shift == link_pkg::COMMA) begin
            state     <= link_pkg::count;
            bit_cnt   <= '0;
            comma_cnt <= CNT_W'(1);
          end
        end
        link_pkg::count: begin
          if (boundary) begin
            if (next_shift == link_pkg::COMMA) begin
              comma_cnt <= comma_cnt + CNT_W'(1);
              if (comma_cnt == CNT_W'(link_pkg::ALIGN_COMMAS - 1)) begin
                state <= link_pkg::locked;
              end
            end else begin
              state <= link_pkg::hunt;  // Boundary was false, search again.
            end
          end
        end
        link_pkg::locked: begin
          // Commas are idle fill and never leave the lane.
          if (boundary && (next_shift != link_pkg::COMMA)) begin
            rx_valid <= 1'b1;
          end
        end
        default: begin
          state <= link_pkg::hunt;
        end
      endcase
    end
  end

  always_ff @(posedge clk8f) begin
    if (boundary) begin
      rx_byte <= next_shift;  // Qualified by rx_valid.
    end
  end

endmodule

`default_nettype wire

/* rtl/fifo/lane_fifo.sv */
/*
  Per-lane show-ahead byte FIFO with almost-full and sticky overflow.
*/
`timescale 1ns/1ps
`default_nettype none

module lane_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire                  clk8f,
  input  wire                  rst,
  input  wire link_pkg::byte_t wr_data,
  input  wire                  wr_en,
  output link_pkg::byte_t      rd_data,
  output logic                 empty,
  input  wire                  pop,
  output logic                 almost_full,
  output logic                 overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  link_pkg::byte_t  mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full        = (fill == CNT_W'(FIFO_DEPTH));
  assign empty       = (fill == '0);
  assign almost_full = (fill >= CNT_W'(FIFO_DEPTH - 1));
  assign do_wr       = wr_en && !full;   // The serial side cannot stall.
  assign do_rd       = pop && !empty;
  assign rd_data     = mem[rd_ptr];      // Head byte shown without delay.

  always_ff @(posedge clk8f) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      if (do_wr && !do_rd) begin
        fill <= fill + CNT_W'(1);
      end else if (do_rd && !do_wr) begin
        fill <= fill - CNT_W'(1);
      end
      if (wr_en && full) begin
        overflow <= 1'b1;  // Held until reset.
      end
    end
  end

  always_ff @(posedge clk8f) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/link_rx_top.sv */
/*
  Two-lane serial link receiver top level: one deserializer, lane FIFO
  and credit output stage per lane.
*/
`timescale 1ns/1ps
`default_nettype none

module link_rx_top #(
  parameter int LANES      = 2,
  parameter int FIFO_DEPTH = 4,
  parameter int CREDITS    = 2
) (
  input  wire                                clk8f,
  input  wire                                rst,
  input  wire  [LANES-1:0]                   ser_in,
  input  wire  [LANES-1:0]                   credit_return,
  output link_pkg::byte_t [LANES-1:0]        out_data,
  output logic [LANES-1:0]                   out_valid,
  output logic [LANES-1:0]                   lane_active,
  output logic [LANES-1:0]                   almost_full,
  output logic [LANES-1:0]                   overflow
);

  genvar i;

  generate
    for (i = 0; i < LANES; i++) begin : g_lane
      link_pkg::byte_t rx_byte;
      link_pkg::byte_t head_data;
      logic            rx_valid;
      logic            empty;
      logic            pop;

      serial_to_parallel u_deser (
        .clk8f    (clk8f),
        .rst      (rst),
        .ser_in   (ser_in[i]),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .active   (lane_active[i])
      );

      lane_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
      ) u_fifo (
        .clk8f       (clk8f),
        .rst         (rst),
        .wr_data     (rx_byte),
        .wr_en       (rx_valid),
        .rd_data     (head_data),
        .empty       (empty),
        .pop         (pop),
        .almost_full (almost_full[i]),
        .overflow    (overflow[i])
      );

      credit_out #(
        .CREDITS (CREDITS)
      ) u_out (
        .clk8f         (clk8f),
        .rst           (rst),
        .head_data     (head_data),
        .empty         (empty),
        .pop           (pop),
        .credit_return (credit_return[i]),
        .out_data      (out_data[i]),
        .out_valid     (out_valid[i])
      );
    end
  endgenerate

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the link receiver testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_link_rx -f src.f -Mdir obj_dir -o tb_link_rx_sim

./obj_dir/tb_link_rx_sim | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

/* src.f */
common/link_pkg.sv
rtl/deser/serial_to_parallel.sv
rtl/fifo/lane_fifo.sv
rtl/credit_out.sv
rtl/link_rx_top.sv
verif/tb_link_rx.sv

/* verif/tb_link_rx.sv */
/*
  Testbench for the two-lane link receiver: random serial stimulus, a
  credit-returning consumer, a byte model per lane, flag checks and a timeout.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_link_rx;

  localparam int LANES      = 2;
  localparam int FIFO_DEPTH = 4;
  localparam int CREDITS    = 2;
  localparam int DATA_BYTES = 40;
  localparam int HELD       = CREDITS + FIFO_DEPTH;  // Bytes a lane keeps with no returns.
  localparam int BURST      = HELD + 1;

  logic                        clk8f = 1'b0;
  logic                        rst;
  logic [LANES-1:0]            ser_in;
  logic [LANES-1:0]            credit_return;
  link_pkg::byte_t [LANES-1:0] out_data;
  logic [LANES-1:0]            out_valid;
  logic [LANES-1:0]            lane_active;
  logic [LANES-1:0]            almost_full;
  logic [LANES-1:0]            overflow;

  bit              bitq [LANES][$];       // Serial bits still to send, MSB first.
  link_pkg::byte_t exp_q [LANES][$];      // Data bytes the consumer must see next.
  link_pkg::byte_t burst [LANES][BURST];
  int              filler [LANES];
  int              stim_len [LANES];
  int              sent [LANES];
  int              recv [LANES];
  int              returned [LANES];
  int              target [LANES];
  logic            credits_on;
  int              errors = 0;
  int              cycles = 0;
  int              limit = 0;

  link_rx_top #(
    .LANES      (LANES),
    .FIFO_DEPTH (FIFO_DEPTH),
    .CREDITS    (CREDITS)
  ) UUT (
    .clk8f         (clk8f),
    .rst           (rst),
    .ser_in        (ser_in),
    .credit_return (credit_return),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .lane_active   (lane_active),
    .almost_full   (almost_full),
    .overflow      (overflow)
  );

  always #4 clk8f = ~clk8f;

  always @(posedge clk8f) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  task automatic push_byte(input int l, input link_pkg::byte_t v);
    for (int b = 7; b >= 0; b--) begin
      bitq[l].push_back(v[b]);
    end
  endtask

  function automatic link_pkg::byte_t random_data();
    link_pkg::byte_t v;
    v = 8'($urandom);
    if (v == link_pkg::COMMA) begin
      v = v ^ 8'h01;  // Data never looks like a comma.
    end
    return v;
  endfunction

  task automatic check_reset_state(input string when);
    for (int l = 0; l < LANES; l++) begin
      check_value(32'(out_valid[l]), 32'd0, $sformatf("lane %0d out_valid %s reset", l, when));
      check_value(32'(lane_active[l]), 32'd0, $sformatf("lane %0d lane_active %s reset", l, when));
      check_value(32'(almost_full[l]), 32'd0, $sformatf("lane %0d almost_full %s reset", l, when));
      check_value(32'(overflow[l]), 32'd0, $sformatf("lane %0d overflow %s reset", l, when));
    end
  endtask

  task automatic monitor_outputs();
    logic            exp_active;
    link_pkg::byte_t want;
    for (int l = 0; l < LANES; l++) begin
      // Lock shows one bit after the last bit of the fourth comma.
      exp_active = (sent[l] >= filler[l] + link_pkg::ALIGN_COMMAS * 8 + 1);
      check_value(32'(lane_active[l]), 32'(exp_active), $sformatf("lane %0d lane_active", l));
      if (out_valid[l]) begin
        check_value(32'(lane_active[l]), 32'd1, $sformatf("lane %0d byte before lock", l));
        if (exp_q[l].size() == 0) begin
          check_value(32'(out_valid[l]), 32'd0, $sformatf("lane %0d byte not expected", l));
        end else begin
          want = exp_q[l].pop_front();
          check_value(32'(out_data[l]), 32'(want), $sformatf("lane %0d data byte", l));
        end
        recv[l]++;
      end
      check_value(32'(recv[l] - returned[l] > CREDITS), 32'd0,
                  $sformatf("lane %0d bytes beyond credit limit", l));
    end
  endtask

  task drive_inputs();
    for (int l = 0; l < LANES; l++) begin
      if (bitq[l].size() == 0) begin
        push_byte(l, link_pkg::COMMA);  // Idle fill keeps the byte boundary.
      end
      ser_in[l] <= bitq[l].pop_front();
      sent[l]++;
      if (credits_on && recv[l] > returned[l] && ($urandom % 2) == 0) begin
        credit_return[l] <= 1'b1;
        returned[l]++;
      end else begin
        credit_return[l] <= 1'b0;
      end
    end
  endtask

  task step();
    @(posedge clk8f);
    drive_inputs();
    @(negedge clk8f);
    monitor_outputs();
  endtask

  function automatic logic drained();
    logic done;
    done = 1'b1;
    for (int l = 0; l < LANES; l++) begin
      if (sent[l] < stim_len[l] || exp_q[l].size() != 0 || recv[l] != returned[l]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  function automatic logic targets_reached();
    logic done;
    done = 1'b1;
    for (int l = 0; l < LANES; l++) begin
      if (sent[l] < target[l]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  initial begin
    link_pkg::byte_t want;
    void'($urandom(34));
    rst = 1'b1;
    ser_in = '0;
    credit_return = '0;
    credits_on = 1'b1;
    for (int l = 0; l < LANES; l++) begin
      sent[l] = 0;
      recv[l] = 0;
      returned[l] = 0;
      filler[l] = int'($urandom % 8);
      repeat (filler[l]) bitq[l].push_back(1'b0);
      repeat (6) push_byte(l, link_pkg::COMMA);
      for (int i = 0; i < DATA_BYTES; i++) begin
        if (($urandom % 4) == 0) begin
          push_byte(l, link_pkg::COMMA);  // Idle comma between data.
        end
        want = random_data();
        push_byte(l, want);
        exp_q[l].push_back(want);
      end
      stim_len[l] = bitq[l].size();
      for (int n = 0; n < BURST; n++) begin
        burst[l][n] = random_data();
      end
      limit += 2 * (stim_len[l] + BURST * 16);
    end
    limit += 200;

    repeat (4) begin
      @(posedge clk8f);
      @(negedge clk8f);
      check_reset_state("during");
    end
    @(posedge clk8f);
    rst <= 1'b0;
    step();
    check_reset_state("after");

    while (!drained()) step();

    // Without returns a lane holds CREDITS bytes downstream plus a full FIFO.
    credits_on = 1'b0;
    for (int n = 1; n <= BURST; n++) begin
      for (int l = 0; l < LANES; l++) begin
        target[l] = sent[l] + bitq[l].size() + 16;
        push_byte(l, burst[l][n - 1]);
        if (n <= HELD) begin
          exp_q[l].push_back(burst[l][n - 1]);
        end
        push_byte(l, link_pkg::COMMA);
      end
      while (!targets_reached()) step();
      for (int l = 0; l < LANES; l++) begin
        check_value(32'(almost_full[l]), 32'(n >= HELD - 1),
                    $sformatf("lane %0d almost_full after %0d held bytes", l, n));
        check_value(32'(overflow[l]), 32'(n > HELD),
                    $sformatf("lane %0d overflow after %0d held bytes", l, n));
      end
    end
    credits_on = 1'b1;
    while (!drained()) step();
    repeat (20) step();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
